/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    localparam int XLEN      = 32;  // RV32 word and address width
    localparam int REG_IDX_W = 5;   // 32 architectural registers
    localparam int OPCODE_W  = 7;   // major opcode, inst[6:0]

    // ************************************************************
    // opcode classes, values are the major opcode encodings
    // ************************************************************
    typedef enum logic [OPCODE_W-1:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_IMM     = 7'b0010011,
        OP_REG     = 7'b0110011,
        OP_SYSTEM  = 7'b1110011,
        OP_ILLEGAL = 7'b0000000   // any encoding not listed above
    } rv_opcode_e;

    // immediate layouts of the base ISA
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE   // register-register and illegal words
    } rv_imm_fmt_e;

endpackage

/* src/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // ************************************************************
    // front end control types
    // ************************************************************

    // next pc source, picked by the hazard unit
    typedef enum logic [1:0] {
        PC_SEQ,     // pc + 4
        PC_BRANCH,  // taken branch or jal from execute
        PC_JALR     // jalr target, bit 0 cleared in pc_gen
    } pc_src_e;

    // IF/ID payload
    typedef struct packed {
        logic                           valid;
        logic [rv_isa_pkg::XLEN-1:0]    pc;
        logic [rv_isa_pkg::XLEN-1:0]    inst;
    } if_id_t;

endpackage

/* src/pipe_ctrl_if.sv */
`timescale 1ns/10ps

interface pipe_ctrl_if;
    import pipe_ctrl_pkg::*;

    logic    stall_pc;     // hold the pc register
    logic    stall_if_id;  // hold IF/ID
    logic    flush_if_id;  // drop the word in IF/ID
    logic    flush_id_ex;  // load a bubble into ID/EX
    pc_src_e pc_src;

    modport ctrl (
        output stall_pc, stall_if_id, flush_if_id, flush_id_ex, pc_src
    );

    modport pc_gen (input stall_pc, pc_src);

    modport if_id (input stall_if_id, flush_if_id);

    modport decode (input flush_id_ex);

endinterface

/* src/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        cpu_clk,
    input  logic                        reset_i,
    pipe_ctrl_if.pc_gen                 ctrl,
    input  logic [rv_isa_pkg::XLEN-1:0] branch_target_i,
    input  logic [rv_isa_pkg::XLEN-1:0] jalr_target_i,
    output logic [rv_isa_pkg::XLEN-1:0] pc_o
);
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4 = pc_q + XLEN'(4);

    // ************************************************************
    // next pc select
    // ************************************************************
    always_comb begin
        case (ctrl.pc_src)
            PC_BRANCH: pc_next = branch_target_i;
            PC_JALR:   pc_next = {jalr_target_i[XLEN-1:1], 1'b0};  // jalr drops bit 0
            default:   pc_next = pc_plus4;
        endcase
    end

    // ************************************************************
    // pc register
    // ************************************************************
    always_ff @(posedge cpu_clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (!ctrl.stall_pc) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;  // instruction memory answers in the same cycle

    // alignment relies on execute sending word-aligned targets
    pc_aligned_a: assert property (
        @(posedge cpu_clk) disable iff (reset_i)
        pc_o[1:0] == 2'b00
    ) else $error("pc_gen: misaligned pc %h", pc_o);

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
    input  logic     inst_mem_hazard_i,
    input  logic     data_mem_hazard_i,
    input  logic     ex_take_branch_i,
    input  logic     ex_take_jalr_i,
    pipe_ctrl_if.ctrl ctrl
);
    import pipe_ctrl_pkg::*;

    always_comb begin
        // default is a free-running front end
        ctrl.pc_src      = PC_SEQ;
        ctrl.stall_pc    = 1'b0;
        ctrl.stall_if_id = 1'b0;
        ctrl.flush_if_id = 1'b0;
        ctrl.flush_id_ex = 1'b0;

        if (ex_take_jalr_i || ex_take_branch_i) begin
            // redirect kills both younger words, stalls are ignored
            ctrl.pc_src      = ex_take_jalr_i ? PC_JALR : PC_BRANCH;
            ctrl.flush_if_id = 1'b1;
            ctrl.flush_id_ex = 1'b1;
        end else if (data_mem_hazard_i) begin
            ctrl.stall_pc    = 1'b1;
            ctrl.stall_if_id = 1'b1;
            ctrl.flush_id_ex = 1'b1;  // bubble into execute
        end else if (inst_mem_hazard_i) begin
            ctrl.stall_pc    = 1'b1;
            ctrl.flush_if_id = 1'b1;  // fetched word not ready
        end
    end

    // execute resolves one control transfer per cycle
    redirect_onehot_a: assert final (
        $isunknown({ex_take_branch_i, ex_take_jalr_i}) ||
        !(ex_take_branch_i && ex_take_jalr_i)
    ) else $error("hazard_unit: branch and jalr redirect together");

endmodule

/* src/if_id_stage.sv */
`timescale 1ns/10ps

module if_id_stage (
    input  logic                        cpu_clk,
    input  logic                        reset_i,
    pipe_ctrl_if.if_id                  ctrl,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] inst_i,
    output pipe_ctrl_pkg::if_id_t       if_id_o
);
    import pipe_ctrl_pkg::*;

    if_id_t if_id_q;

    // ************************************************************
    // IF/ID register
    // ************************************************************
    always_ff @(posedge cpu_clk) begin
        if (reset_i) begin
            if_id_q.valid <= 1'b0;
        end else if (ctrl.flush_if_id) begin
            if_id_q.valid <= 1'b0;  // flush wins over stall
        end else if (!ctrl.stall_if_id) begin
            if_id_q <= '{valid: 1'b1, pc: pc_i, inst: inst_i};
        end
    end

    assign if_id_o = if_id_q;

    // a stalled stage keeps its word for the decode stage
    if_id_hold_a: assert property (
        @(posedge cpu_clk) disable iff (reset_i)
        (ctrl.stall_if_id && !ctrl.flush_if_id) |=> $stable(if_id_q)
    ) else $error("if_id_stage: register changed under stall");

endmodule

/* src/inst_decode.sv */
`timescale 1ns/10ps

module inst_decode (
    input  logic                             cpu_clk,
    input  logic                             reset_i,
    pipe_ctrl_if.decode                      ctrl,
    input  pipe_ctrl_pkg::if_id_t            if_id_i,
    output logic                             id_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]      id_pc_o,
    output rv_isa_pkg::rv_opcode_e           id_opcode_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rd_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rs1_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rs2_o,
    output logic [rv_isa_pkg::XLEN-1:0]      id_imm_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] inst;
    rv_opcode_e      opcode_d;
    rv_imm_fmt_e     imm_fmt;
    logic [XLEN-1:0] imm_d;

    assign inst = if_id_i.inst;

    // ************************************************************
    // opcode class and immediate format
    // ************************************************************
    always_comb begin
        case (inst[OPCODE_W-1:0])
            OP_LUI:    opcode_d = OP_LUI;
            OP_AUIPC:  opcode_d = OP_AUIPC;
            OP_JAL:    opcode_d = OP_JAL;
            OP_JALR:   opcode_d = OP_JALR;
            OP_BRANCH: opcode_d = OP_BRANCH;
            OP_LOAD:   opcode_d = OP_LOAD;
            OP_STORE:  opcode_d = OP_STORE;
            OP_IMM:    opcode_d = OP_IMM;
            OP_REG:    opcode_d = OP_REG;
            OP_SYSTEM: opcode_d = OP_SYSTEM;
            default:   opcode_d = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (opcode_d)
            OP_LUI, OP_AUIPC:                    imm_fmt = IMM_U;
            OP_JAL:                              imm_fmt = IMM_J;
            OP_BRANCH:                           imm_fmt = IMM_B;
            OP_STORE:                            imm_fmt = IMM_S;
            OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM: imm_fmt = IMM_I;
            default:                             imm_fmt = IMM_NONE;
        endcase
    end

    // sign-extended immediates, bit 31 is always the sign
    always_comb begin
        case (imm_fmt)
            IMM_I: imm_d = {{(XLEN-12){inst[31]}}, inst[31:20]};
            IMM_S: imm_d = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B: imm_d = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U: imm_d = {inst[31:12], 12'b0};
            IMM_J: imm_d = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm_d = '0;
        endcase
    end

    // ************************************************************
    // ID/EX register
    // ************************************************************
    always_ff @(posedge cpu_clk) begin
        if (reset_i || ctrl.flush_id_ex) begin
            id_valid_o <= 1'b0;  // bubble
        end else begin
            id_valid_o <= if_id_i.valid;
        end
    end

    always_ff @(posedge cpu_clk) begin
        id_pc_o     <= if_id_i.pc;
        id_opcode_o <= opcode_d;
        id_rd_o     <= inst[11:7];
        id_rs1_o    <= inst[19:15];
        id_rs2_o    <= inst[24:20];
        id_imm_o    <= imm_d;
    end

    // upper immediates reach execute with a clean low part
    upper_imm_a: assert property (
        @(posedge cpu_clk) disable iff (reset_i)
        (if_id_i.valid && !ctrl.flush_id_ex && opcode_d inside {OP_LUI, OP_AUIPC})
            |=> id_imm_o[11:0] == 12'h000
    ) else $error("inst_decode: U-type immediate with low bits set");

endmodule

/* src/cpu_frontend.sv */
`timescale 1ns/10ps

module cpu_frontend #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                             cpu_clk,
    input  logic                             reset_i,

    // instruction memory
    output logic [rv_isa_pkg::XLEN-1:0]      pc_o,
    input  logic [rv_isa_pkg::XLEN-1:0]      inst_i,
    input  logic                             inst_mem_hazard_i,
    input  logic                             data_mem_hazard_i,

    // redirects from execute
    input  logic                             ex_take_branch_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      ex_branch_target_i,
    input  logic                             ex_take_jalr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      ex_jalr_target_i,

    // ID/EX towards execute
    output logic                             id_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]      id_pc_o,
    output rv_isa_pkg::rv_opcode_e           id_opcode_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rd_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rs1_o,
    output logic [rv_isa_pkg::REG_IDX_W-1:0] id_rs2_o,
    output logic [rv_isa_pkg::XLEN-1:0]      id_imm_o
);
    import pipe_ctrl_pkg::*;

    if_id_t if_id;

    pipe_ctrl_if ctrl_if ();

    hazard_unit hazard_unit_inst (
        .inst_mem_hazard_i (inst_mem_hazard_i),
        .data_mem_hazard_i (data_mem_hazard_i),
        .ex_take_branch_i  (ex_take_branch_i),
        .ex_take_jalr_i    (ex_take_jalr_i),
        .ctrl              (ctrl_if.ctrl)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_inst (
        .cpu_clk         (cpu_clk),
        .reset_i         (reset_i),
        .ctrl            (ctrl_if.pc_gen),
        .branch_target_i (ex_branch_target_i),
        .jalr_target_i   (ex_jalr_target_i),
        .pc_o            (pc_o)
    );

    if_id_stage if_id_stage_inst (
        .cpu_clk (cpu_clk),
        .reset_i (reset_i),
        .ctrl    (ctrl_if.if_id),
        .pc_i    (pc_o),
        .inst_i  (inst_i),
        .if_id_o (if_id)
    );

    inst_decode inst_decode_inst (
        .cpu_clk     (cpu_clk),
        .reset_i     (reset_i),
        .ctrl        (ctrl_if.decode),
        .if_id_i     (if_id),
        .id_valid_o  (id_valid_o),
        .id_pc_o     (id_pc_o),
        .id_opcode_o (id_opcode_o),
        .id_rd_o     (id_rd_o),
        .id_rs1_o    (id_rs1_o),
        .id_rs2_o    (id_rs2_o),
        .id_imm_o    (id_imm_o)
    );

endmodule

/* tests/cpu_frontend_tb.sv */
`timescale 1ns/10ps

module cpu_frontend_tb;
    import rv_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0040;
    localparam int              TEST_CYCLES = 500;
    localparam int              MAX_CYCLES  = 4 * TEST_CYCLES;

    logic                 cpu_clk = 1'b0;
    logic                 reset_i;
    logic [XLEN-1:0]      pc_o;
    logic [XLEN-1:0]      inst_i;
    logic                 inst_mem_hazard_i;
    logic                 data_mem_hazard_i;
    logic                 ex_take_branch_i;
    logic [XLEN-1:0]      ex_branch_target_i;
    logic                 ex_take_jalr_i;
    logic [XLEN-1:0]      ex_jalr_target_i;
    logic                 id_valid_o;
    logic [XLEN-1:0]      id_pc_o;
    rv_opcode_e           id_opcode_o;
    logic [REG_IDX_W-1:0] id_rd_o;
    logic [REG_IDX_W-1:0] id_rs1_o;
    logic [REG_IDX_W-1:0] id_rs2_o;
    logic [XLEN-1:0]      id_imm_o;

    logic [XLEN-1:0] imem [256];
    logic [31:0]     lfsr = 32'h5b09;
    int              cycle_count = 0;
    logic            redirect;
    logic            quiet;

    cpu_frontend #(
        .RESET_PC (RESET_PC)
    ) cpu_frontend_inst (
        .cpu_clk            (cpu_clk),
        .reset_i            (reset_i),
        .pc_o               (pc_o),
        .inst_i             (inst_i),
        .inst_mem_hazard_i  (inst_mem_hazard_i),
        .data_mem_hazard_i  (data_mem_hazard_i),
        .ex_take_branch_i   (ex_take_branch_i),
        .ex_branch_target_i (ex_branch_target_i),
        .ex_take_jalr_i     (ex_take_jalr_i),
        .ex_jalr_target_i   (ex_jalr_target_i),
        .id_valid_o         (id_valid_o),
        .id_pc_o            (id_pc_o),
        .id_opcode_o        (id_opcode_o),
        .id_rd_o            (id_rd_o),
        .id_rs1_o           (id_rs1_o),
        .id_rs2_o           (id_rs2_o),
        .id_imm_o           (id_imm_o)
    );

    always #20 cpu_clk = ~cpu_clk;

    assign inst_i   = imem[pc_o[9:2]];  // combinational instruction memory
    assign redirect = ex_take_jalr_i || ex_take_branch_i;
    assign quiet    = !reset_i && !redirect && !inst_mem_hazard_i && !data_mem_hazard_i;

    // ************************************************************
    // random source and reference decode
    // ************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // mostly legal opcodes plus a few encodings that must decode as illegal
    function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:  return 7'b0110111;
            4'd1:  return 7'b0010111;
            4'd2:  return 7'b1101111;
            4'd3:  return 7'b1100111;
            4'd4:  return 7'b1100011;
            4'd5:  return 7'b0000011;
            4'd6:  return 7'b0100011;
            4'd7:  return 7'b0010011;
            4'd8:  return 7'b0110011;
            4'd9:  return 7'b1110011;
            4'd10: return 7'b0010011;
            4'd11: return 7'b0110011;
            4'd12: return 7'b0001111;  // fence is not decoded here
            4'd13: return 7'b1111111;
            4'd14: return 7'b0000000;
            default: return 7'b1010101;
        endcase
    endfunction

    function automatic rv_opcode_e exp_opcode(input logic [31:0] w);
        case (w[6:0])
            7'b0110111: return OP_LUI;
            7'b0010111: return OP_AUIPC;
            7'b1101111: return OP_JAL;
            7'b1100111: return OP_JALR;
            7'b1100011: return OP_BRANCH;
            7'b0000011: return OP_LOAD;
            7'b0100011: return OP_STORE;
            7'b0010011: return OP_IMM;
            7'b0110011: return OP_REG;
            7'b1110011: return OP_SYSTEM;
            default:    return OP_ILLEGAL;
        endcase
    endfunction

    // base ISA immediate layout per major opcode
    function automatic rv_imm_fmt_e fmt_of(input logic [6:0] opc);
        case (opc)
            7'b0110111, 7'b0010111:                         return IMM_U;
            7'b1101111:                                     return IMM_J;
            7'b1100011:                                     return IMM_B;
            7'b0100011:                                     return IMM_S;
            7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: return IMM_I;
            default:                                        return IMM_NONE;
        endcase
    endfunction

    function automatic logic [31:0] exp_imm(input logic [31:0] w);
        case (fmt_of(w[6:0]))
            IMM_I: return {{21{w[31]}}, w[30:20]};
            IMM_S: return {{21{w[31]}}, w[30:25], w[11:7]};
            IMM_B: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U: return {w[31:12], 12'h000};
            IMM_J: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic bit decode_ok(input logic [31:0] w, input rv_opcode_e op,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [31:0] imm);
        return op == exp_opcode(w) && rd == w[11:7] && rs1 == w[19:15]
            && rs2 == w[24:20] && imm == exp_imm(w);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic fill_imem();
        logic [31:0] sel;
        logic [31:0] hi;
        for (int a = 0; a < 256; a++) begin
            draw_bits(4, sel);
            draw_bits(25, hi);  // register fields and immediate bits
            imem[a] = {hi[24:0], pick_opcode(sel[3:0])};
        end
    endtask

    // one cycle of hazards and redirects with at most one redirect
    task automatic drive_cycle();
        logic [31:0] r;
        draw_bits(5, r);
        ex_take_jalr_i   <= (r == 0);
        ex_take_branch_i <= (r == 1);
        draw_bits(8, r);
        ex_branch_target_i <= {22'b0, r[7:0], 2'b00};
        draw_bits(9, r);
        ex_jalr_target_i <= {22'b0, r[8:1], 1'b0, r[0]};  // bit 0 set at times
        draw_bits(4, r);
        data_mem_hazard_i <= (r == 0);
        inst_mem_hazard_i <= (r == 1) || (r == 2);
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    reset_state_a: assert property (@(posedge cpu_clk)
        $fell(reset_i) |-> (pc_o == RESET_PC && !id_valid_o)
    ) else report_mismatch($sformatf("after reset pc_o %h id_valid_o %b", pc_o, id_valid_o));

    seq_fetch_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        quiet |=> pc_o == $past(pc_o) + 32'd4
    ) else report_mismatch($sformatf("sequential fetch gave pc_o %h", pc_o));

    jalr_target_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        ex_take_jalr_i |=> pc_o == {$past(ex_jalr_target_i[31:1]), 1'b0}
    ) else report_mismatch($sformatf("jalr redirect gave pc_o %h", pc_o));

    branch_target_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        (ex_take_branch_i && !ex_take_jalr_i) |=> pc_o == $past(ex_branch_target_i)
    ) else report_mismatch($sformatf("branch redirect gave pc_o %h", pc_o));

    redirect_flush_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        redirect |=> !id_valid_o ##1 !id_valid_o
    ) else report_mismatch("valid output inside the redirect shadow");

    stall_hold_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        (!redirect && (inst_mem_hazard_i || data_mem_hazard_i)) |=> $stable(pc_o)
    ) else report_mismatch($sformatf("pc_o moved to %h under a hazard", pc_o));

    inst_bubble_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        (!redirect && !data_mem_hazard_i && inst_mem_hazard_i) |=> ##1 !id_valid_o
    ) else report_mismatch("no bubble after instruction memory hazard");

    data_bubble_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        (!redirect && data_mem_hazard_i) |=> !id_valid_o
    ) else report_mismatch("no bubble after data memory hazard");

    decode_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        id_valid_o |-> decode_ok(imem[id_pc_o[9:2]], id_opcode_o, id_rd_o,
                                 id_rs1_o, id_rs2_o, id_imm_o)
    ) else report_mismatch($sformatf("decode of word at %h, opcode %s imm %h",
                                     id_pc_o, id_opcode_o.name(), id_imm_o));

    pc_order_a: assert property (@(posedge cpu_clk) disable iff (reset_i)
        (id_valid_o && quiet) |=> (!id_valid_o || id_pc_o == $past(id_pc_o) + 32'd4)
    ) else report_mismatch($sformatf("out of order id_pc_o %h", id_pc_o));

    // ************************************************************
    // run control
    // ************************************************************
    always @(posedge cpu_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset_i            = 1'b1;
        inst_mem_hazard_i  = 1'b0;
        data_mem_hazard_i  = 1'b0;
        ex_take_branch_i   = 1'b0;
        ex_branch_target_i = '0;
        ex_take_jalr_i     = 1'b0;
        ex_jalr_target_i   = '0;
        fill_imem();
        repeat (3) @(posedge cpu_clk);
        reset_i <= 1'b0;
        repeat (TEST_CYCLES) begin
            @(posedge cpu_clk);
            drive_cycle();
        end
        @(posedge cpu_clk);
        @(posedge cpu_clk);  // let the last checks resolve
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* cpu_frontend.f */
src/rv_isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/pipe_ctrl_if.sv
src/pc_gen.sv
src/hazard_unit.sv
src/if_id_stage.sv
src/inst_decode.sv
src/cpu_frontend.sv
tests/cpu_frontend_tb.sv

/* Bender.yml */
package:
  name: cpu_frontend

sources:
  - src/rv_isa_pkg.sv
  - src/pipe_ctrl_pkg.sv
  - src/pipe_ctrl_if.sv
  - src/pc_gen.sv
  - src/hazard_unit.sv
  - src/if_id_stage.sv
  - src/inst_decode.sv
  - src/cpu_frontend.sv
  - target: test
    files:
      - tests/cpu_frontend_tb.sv
